/* lite_regs_pkg.sv */
// ----------------------------------------------------------
// Shared constants for the coefficient register block.
// Register count, index width and AXI4-Lite response codes.
// ----------------------------------------------------------

package lite_regs_pkg;

    // ----------------------------------------------------------
    // Register map
    // ----------------------------------------------------------

    // Number of coefficient registers.
    // Also the number of elements in the input vector.
    localparam int NUM_COEF_REGS = 4;

    // Width of a register index within the address window.
    localparam int REG_IDX_W = $clog2(NUM_COEF_REGS);

    // ----------------------------------------------------------
    // Bus responses
    // ----------------------------------------------------------

    // Two-bit AXI4-Lite response code.
    typedef logic [1:0] axil_resp_t;

    // Normal access completed.
    localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

    // Access rejected by the slave.
    // Used for addresses outside the register window.
    localparam axil_resp_t AXIL_RESP_SLVERR = 2'b10;

endpackage

/* coef_reg_file.sv */
// ----------------------------------------------------------
// Coefficient register file with a byte-strobed write port.
// ----------------------------------------------------------

module coef_reg_file #(
    parameter int DATA_W = 32
) (
    input  logic                                            i_clk,
    input  logic                                            i_sync_rst,
    input  logic                                            i_wr_en,
    input  logic [lite_regs_pkg::REG_IDX_W-1:0]             i_wr_idx,
    input  logic [DATA_W-1:0]                               i_wr_data,
    input  logic [DATA_W/8-1:0]                             i_wr_strb,
    output logic [lite_regs_pkg::NUM_COEF_REGS*DATA_W-1:0]  o_coefs
);

    localparam int NUM_LANES = DATA_W / 8;

    logic [DATA_W-1:0] r_coefs [lite_regs_pkg::NUM_COEF_REGS];

    // Only strobed byte lanes of the addressed register change.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            for (int i = 0; i < lite_regs_pkg::NUM_COEF_REGS; i++) begin
                r_coefs[i] <= '0;
            end
        end else if (i_wr_en) begin
            for (int b = 0; b < NUM_LANES; b++) begin
                if (i_wr_strb[b]) begin
                    r_coefs[i_wr_idx][b*8 +: 8] <= i_wr_data[b*8 +: 8];
                end
            end
        end
    end

    // Flat view for the read mux and the dot product.
    // Register 0 sits in the low word.
    always_comb begin
        for (int i = 0; i < lite_regs_pkg::NUM_COEF_REGS; i++) begin
            o_coefs[i*DATA_W +: DATA_W] = r_coefs[i];
        end
    end

endmodule

/* inner_product_unit.sv */
// ----------------------------------------------------------
// Registered dot product of input vector and coefficients.
// ----------------------------------------------------------

module inner_product_unit #(
    parameter int DATA_W = 32
) (
    input  logic                                            i_clk,
    input  logic                                            i_sync_rst,
    input  logic [lite_regs_pkg::NUM_COEF_REGS*DATA_W-1:0]  i_vec,
    input  logic                                            i_vec_valid,
    input  logic [lite_regs_pkg::NUM_COEF_REGS*DATA_W-1:0]  i_coefs,
    output logic [DATA_W-1:0]                               o_in_prod,
    output logic                                            o_in_prod_valid
);

    logic [DATA_W-1:0] sum;

    // Sum of products, wrapped to DATA_W bits.
    always_comb begin
        sum = '0;
        for (int i = 0; i < lite_regs_pkg::NUM_COEF_REGS; i++) begin
            sum = sum + i_vec[i*DATA_W +: DATA_W] * i_coefs[i*DATA_W +: DATA_W];
        end
    end

    // Result captured only for a valid vector.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            o_in_prod       <= '0;
            o_in_prod_valid <= 1'b0;
        end else begin
            o_in_prod_valid <= i_vec_valid;
            if (i_vec_valid) begin
                o_in_prod <= sum;
            end
        end
    end

    // A strobed vector carries known data.
    a_vec_known : assert property (@(posedge i_clk) disable iff (i_sync_rst)
        i_vec_valid |-> !$isunknown(i_vec));

endmodule

/* axil_write_channel.sv */
// ----------------------------------------------------------
// AXI4-Lite write channel with one outstanding write.
// Address decode, register write strobe and held B response.
// ----------------------------------------------------------

module axil_write_channel #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                                  i_clk,
    input  logic                                  i_sync_rst,
    input  logic                                  i_awvalid,
    input  logic [ADDR_W-1:0]                     i_awaddr,
    input  logic                                  i_wvalid,
    input  logic [DATA_W-1:0]                     i_wdata,
    input  logic [DATA_W/8-1:0]                   i_wstrb,
    input  logic                                  i_bready,
    output logic                                  o_awready,
    output logic                                  o_wready,
    output logic                                  o_bvalid,
    output lite_regs_pkg::axil_resp_t             o_bresp,
    output logic                                  o_reg_wr_en,
    output logic [lite_regs_pkg::REG_IDX_W-1:0]   o_reg_wr_idx,
    output logic [DATA_W-1:0]                     o_reg_wr_data,
    output logic [DATA_W/8-1:0]                   o_reg_wr_strb
);

    // Byte lanes and word offset in the address.
    localparam int NUM_LANES = DATA_W / 8;
    localparam int ADDR_LSB = $clog2(NUM_LANES);
    // First address bit above the register window.
    localparam int WIN_TOP = ADDR_LSB + lite_regs_pkg::REG_IDX_W;

    logic                 r_busy;
    logic                 r_ready;
    logic [ADDR_W-1:0]    r_awaddr;
    logic [DATA_W-1:0]    r_wdata;
    logic [NUM_LANES-1:0] r_wstrb;
    logic                 accept;
    logic                 in_range;

    // New write only when idle and both AW and W are presented.
    assign accept = !r_busy && i_awvalid && i_wvalid;

    // Bits above the window must be zero.
    assign in_range = (r_awaddr[ADDR_W-1:WIN_TOP] == '0);

    // ----------------------------------------------------------
    // Acceptance
    // ----------------------------------------------------------

    // Busy from acceptance until the response is taken.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            r_busy  <= 1'b0;
            r_ready <= 1'b0;
        end else begin
            r_ready <= accept;
            if (accept) begin
                r_busy <= 1'b1;
            end else if (o_bvalid && i_bready) begin
                r_busy <= 1'b0;
            end
        end
    end

    // Address and data are captured with the request.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            r_awaddr <= i_awaddr;
            r_wdata  <= i_wdata;
            r_wstrb  <= i_wstrb;
        end
    end

    assign o_awready = r_ready;
    assign o_wready  = r_ready;

    // Register write during the ready cycle.
    // Out-of-range writes leave the registers alone.
    assign o_reg_wr_en   = r_ready && in_range;
    assign o_reg_wr_idx  = r_awaddr[ADDR_LSB +: lite_regs_pkg::REG_IDX_W];
    assign o_reg_wr_data = r_wdata;
    assign o_reg_wr_strb = r_wstrb;

    // ----------------------------------------------------------
    // Write response
    // ----------------------------------------------------------

    // Response rises with the handshake edge and holds until BREADY.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            o_bvalid <= 1'b0;
            o_bresp  <= lite_regs_pkg::AXIL_RESP_OKAY;
        end else if (r_ready) begin
            o_bvalid <= 1'b1;
            o_bresp  <= in_range ? lite_regs_pkg::AXIL_RESP_OKAY
                                 : lite_regs_pkg::AXIL_RESP_SLVERR;
        end else if (o_bvalid && i_bready) begin
            o_bvalid <= 1'b0;
        end
    end

    // Response stays up and unchanged while the master stalls.
    a_bresp_held : assert property (@(posedge i_clk) disable iff (i_sync_rst)
        (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_bresp)));

endmodule

/* axil_read_channel.sv */
// ----------------------------------------------------------
// AXI4-Lite read channel with registered read data.
// ----------------------------------------------------------

module axil_read_channel #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                                            i_clk,
    input  logic                                            i_sync_rst,
    input  logic                                            i_arvalid,
    input  logic [ADDR_W-1:0]                               i_araddr,
    input  logic                                            i_rready,
    input  logic [lite_regs_pkg::NUM_COEF_REGS*DATA_W-1:0]  i_coefs,
    output logic                                            o_arready,
    output logic                                            o_rvalid,
    output logic [DATA_W-1:0]                               o_rdata,
    output lite_regs_pkg::axil_resp_t                       o_rresp
);

    // Word offset and top of the register window.
    localparam int ADDR_LSB = $clog2(DATA_W / 8);
    localparam int WIN_TOP = ADDR_LSB + lite_regs_pkg::REG_IDX_W;

    logic [ADDR_W-1:0]                   r_araddr;
    logic [lite_regs_pkg::REG_IDX_W-1:0] rd_idx;
    logic                                in_range;
    logic [DATA_W-1:0]                   rd_word;

    assign rd_idx   = r_araddr[ADDR_LSB +: lite_regs_pkg::REG_IDX_W];
    assign in_range = (r_araddr[ADDR_W-1:WIN_TOP] == '0);
    // Out-of-range reads return zero.
    assign rd_word  = in_range ? i_coefs[rd_idx*DATA_W +: DATA_W] : '0;

    // ----------------------------------------------------------
    // Address acceptance
    // ----------------------------------------------------------

    // One-cycle ARREADY pulse.
    // No new address while read data is still waiting.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            o_arready <= 1'b0;
        end else begin
            o_arready <= !o_arready && !o_rvalid && i_arvalid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!o_arready && !o_rvalid && i_arvalid) begin
            r_araddr <= i_araddr;
        end
    end

    // ----------------------------------------------------------
    // Read data
    // ----------------------------------------------------------

    // Data and response registered on the handshake edge.
    always_ff @(posedge i_clk) begin
        if (i_sync_rst) begin
            o_rvalid <= 1'b0;
            o_rdata  <= '0;
            o_rresp  <= lite_regs_pkg::AXIL_RESP_OKAY;
        end else if (o_arready) begin
            o_rvalid <= 1'b1;
            o_rdata  <= rd_word;
            o_rresp  <= in_range ? lite_regs_pkg::AXIL_RESP_OKAY
                                 : lite_regs_pkg::AXIL_RESP_SLVERR;
        end else if (o_rvalid && i_rready) begin
            o_rvalid <= 1'b0;
        end
    end

    // Stalled read data does not change under the master.
    a_rdata_held : assert property (@(posedge i_clk) disable iff (i_sync_rst)
        (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata) && $stable(o_rresp)));

endmodule

/* axil_coef_dot_top.sv */
// ----------------------------------------------------------
// AXI4-Lite coefficient block with dot product datapath.
// ----------------------------------------------------------

module axil_coef_dot_top #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                                            i_clk,
    input  logic                                            i_sync_rst,
    // Write address and data.
    input  logic                                            i_awvalid,
    input  logic [ADDR_W-1:0]                               i_awaddr,
    input  logic                                            i_wvalid,
    input  logic [DATA_W-1:0]                               i_wdata,
    input  logic [DATA_W/8-1:0]                             i_wstrb,
    output logic                                            o_awready,
    output logic                                            o_wready,
    // Write response.
    input  logic                                            i_bready,
    output logic                                            o_bvalid,
    output lite_regs_pkg::axil_resp_t                       o_bresp,
    // Read address and data.
    input  logic                                            i_arvalid,
    input  logic [ADDR_W-1:0]                               i_araddr,
    input  logic                                            i_rready,
    output logic                                            o_arready,
    output logic                                            o_rvalid,
    output logic [DATA_W-1:0]                               o_rdata,
    output lite_regs_pkg::axil_resp_t                       o_rresp,
    // Dot product datapath.
    input  logic [lite_regs_pkg::NUM_COEF_REGS*DATA_W-1:0]  i_vec,
    input  logic                                            i_vec_valid,
    output logic [DATA_W-1:0]                               o_in_prod,
    output logic                                            o_in_prod_valid
);

    // ----------------------------------------------------------
    // Internal connections
    // ----------------------------------------------------------

    logic                                            reg_wr_en;
    logic [lite_regs_pkg::REG_IDX_W-1:0]             reg_wr_idx;
    logic [DATA_W-1:0]                               reg_wr_data;
    logic [DATA_W/8-1:0]                             reg_wr_strb;
    // All coefficients, register 0 in the low word.
    logic [lite_regs_pkg::NUM_COEF_REGS*DATA_W-1:0]  coefs;

    axil_write_channel #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_wr_chan (
        .i_clk(i_clk), .i_sync_rst(i_sync_rst),
        .i_awvalid(i_awvalid), .i_awaddr(i_awaddr),
        .i_wvalid(i_wvalid), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
        .i_bready(i_bready),
        .o_awready(o_awready), .o_wready(o_wready),
        .o_bvalid(o_bvalid), .o_bresp(o_bresp),
        .o_reg_wr_en(reg_wr_en), .o_reg_wr_idx(reg_wr_idx),
        .o_reg_wr_data(reg_wr_data), .o_reg_wr_strb(reg_wr_strb)
    );

    axil_read_channel #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_rd_chan (
        .i_clk(i_clk), .i_sync_rst(i_sync_rst),
        .i_arvalid(i_arvalid), .i_araddr(i_araddr), .i_rready(i_rready),
        .i_coefs(coefs),
        .o_arready(o_arready), .o_rvalid(o_rvalid),
        .o_rdata(o_rdata), .o_rresp(o_rresp)
    );

    coef_reg_file #(.DATA_W(DATA_W)) u_regs (
        .i_clk(i_clk), .i_sync_rst(i_sync_rst),
        .i_wr_en(reg_wr_en), .i_wr_idx(reg_wr_idx),
        .i_wr_data(reg_wr_data), .i_wr_strb(reg_wr_strb),
        .o_coefs(coefs)
    );

    inner_product_unit #(.DATA_W(DATA_W)) u_dot (
        .i_clk(i_clk), .i_sync_rst(i_sync_rst),
        .i_vec(i_vec), .i_vec_valid(i_vec_valid), .i_coefs(coefs),
        .o_in_prod(o_in_prod), .o_in_prod_valid(o_in_prod_valid)
    );

endmodule

/* tb_axil_coef_dot.sv */
// ----------------------------------------------------------
// Random self-checking testbench for the coefficient block.
// Bus tasks, register and dot product model, checks.
// ----------------------------------------------------------

module tb_axil_coef_dot;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int NREG = lite_regs_pkg::NUM_COEF_REGS;
    // Word offset for 32-bit data and first bit above the window.
    localparam int ADDR_LSB = 2;
    localparam int WIN_TOP = ADDR_LSB + lite_regs_pkg::REG_IDX_W;

    // ----------------------------------------------------------
    // Test lengths and watchdog budget
    // ----------------------------------------------------------

    localparam int N_FULL = 16;
    localparam int N_STRB = 16;
    localparam int N_BAD = 6;
    localparam int N_DOT_ROUNDS = 8;
    localparam int DOT_BURST = 6;
    localparam int NUM_TXNS = 2 * NREG + 2 * N_FULL + 2 * N_STRB + 2 * N_BAD
                            + N_DOT_ROUNDS * (1 + DOT_BURST);

    logic                       i_clk;
    logic                       i_sync_rst;
    logic                       i_awvalid;
    logic [ADDR_W-1:0]          i_awaddr;
    logic                       i_wvalid;
    logic [DATA_W-1:0]          i_wdata;
    logic [DATA_W/8-1:0]        i_wstrb;
    logic                       i_bready;
    logic                       i_arvalid;
    logic [ADDR_W-1:0]          i_araddr;
    logic                       i_rready;
    logic [NREG*DATA_W-1:0]     i_vec;
    logic                       i_vec_valid;
    logic                       o_awready;
    logic                       o_wready;
    logic                       o_bvalid;
    lite_regs_pkg::axil_resp_t  o_bresp;
    logic                       o_arready;
    logic                       o_rvalid;
    logic [DATA_W-1:0]          o_rdata;
    lite_regs_pkg::axil_resp_t  o_rresp;
    logic [DATA_W-1:0]          o_in_prod;
    logic                       o_in_prod_valid;

    // Reference copy of the coefficient registers.
    logic [DATA_W-1:0] model_coef [NREG];
    logic [31:0]       lcg_state;

    axil_coef_dot_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) UUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // Budget of 40 cycles per transaction plus reset.
    initial begin
        repeat (NUM_TXNS * 40 + 10) @(posedge i_clk);
        $display("Timeout: the DUT stopped responding before all transactions finished.");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    // ----------------------------------------------------------
    // Model and helpers
    // ----------------------------------------------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic addr_in_range(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:WIN_TOP] == '0;
    endfunction

    // Byte-lane merge of a strobed write.
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] data,
                                                      input logic [DATA_W/8-1:0] strb);
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int b = 0; b < DATA_W / 8; b++) begin
            if (strb[b]) word[b*8 +: 8] = data[b*8 +: 8];
        end
        return word;
    endfunction

    // Sum of products, wrapped to the data width.
    function automatic logic [DATA_W-1:0] dot_model(input logic [NREG*DATA_W-1:0] vec);
        logic [DATA_W-1:0] acc;
        acc = '0;
        for (int i = 0; i < NREG; i++) begin
            acc = acc + vec[i*DATA_W +: DATA_W] * model_coef[i];
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // ----------------------------------------------------------
    // Bus tasks
    // ----------------------------------------------------------

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [DATA_W/8-1:0] strb);
        logic [31:0] rnd;
        logic [1:0]  exp_resp;
        exp_resp = addr_in_range(addr) ? lite_regs_pkg::AXIL_RESP_OKAY
                                       : lite_regs_pkg::AXIL_RESP_SLVERR;
        i_awvalid = 1'b1;
        i_awaddr  = addr;
        i_wvalid  = 1'b1;
        i_wdata   = data;
        i_wstrb   = strb;
        do begin
            @(posedge i_clk);
            #1;
        end while (!o_awready);
        check_value("o_wready", 64'd1, 64'(o_wready));
        @(posedge i_clk);
        #1;
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        if (exp_resp == lite_regs_pkg::AXIL_RESP_OKAY) begin
            model_coef[addr[ADDR_LSB +: 2]] = merge_bytes(model_coef[addr[ADDR_LSB +: 2]],
                                                          data, strb);
        end
        while (!o_bvalid) begin
            @(posedge i_clk);
            #1;
        end
        // Stalled response must hold.
        rnd = next_rand();
        repeat (rnd[1:0]) begin
            check_value("o_bvalid", 64'd1, 64'(o_bvalid));
            check_value("o_bresp", 64'(exp_resp), 64'(o_bresp));
            @(posedge i_clk);
            #1;
        end
        check_value("o_bvalid", 64'd1, 64'(o_bvalid));
        check_value("o_bresp", 64'(exp_resp), 64'(o_bresp));
        i_bready = 1'b1;
        @(posedge i_clk);
        #1;
        i_bready = 1'b0;
        check_value("o_bvalid", 64'd0, 64'(o_bvalid));
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr);
        logic [31:0]       rnd;
        logic [1:0]        exp_resp;
        logic [DATA_W-1:0] exp_data;
        exp_resp = addr_in_range(addr) ? lite_regs_pkg::AXIL_RESP_OKAY
                                       : lite_regs_pkg::AXIL_RESP_SLVERR;
        exp_data = addr_in_range(addr) ? model_coef[addr[ADDR_LSB +: 2]] : '0;
        i_arvalid = 1'b1;
        i_araddr  = addr;
        do begin
            @(posedge i_clk);
            #1;
        end while (!o_arready);
        @(posedge i_clk);
        #1;
        i_arvalid = 1'b0;
        while (!o_rvalid) begin
            @(posedge i_clk);
            #1;
        end
        rnd = next_rand();
        repeat (rnd[1:0]) begin
            check_value("o_rvalid", 64'd1, 64'(o_rvalid));
            check_value("o_rdata", 64'(exp_data), 64'(o_rdata));
            check_value("o_rresp", 64'(exp_resp), 64'(o_rresp));
            @(posedge i_clk);
            #1;
        end
        check_value("o_rvalid", 64'd1, 64'(o_rvalid));
        check_value("o_rdata", 64'(exp_data), 64'(o_rdata));
        check_value("o_rresp", 64'(exp_resp), 64'(o_rresp));
        i_rready = 1'b1;
        @(posedge i_clk);
        #1;
        i_rready = 1'b0;
        check_value("o_rvalid", 64'd0, 64'(o_rvalid));
    endtask

    // In-range address with random bits below the word offset.
    function automatic logic [ADDR_W-1:0] good_addr(input logic [1:0] idx);
        logic [31:0] rnd;
        rnd = next_rand();
        return {{(ADDR_W - WIN_TOP){1'b0}}, idx, rnd[1:0]};
    endfunction

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------

    initial begin
        logic [31:0]       rnd;
        logic [ADDR_W-1:0] addr;
        logic              send;
        logic [DATA_W-1:0] exp_prod;
        lcg_state = 32'h2c0f0a36;
        for (int i = 0; i < NREG; i++) model_coef[i] = '0;
        i_sync_rst  = 1'b1;
        i_awvalid   = 1'b0;
        i_awaddr    = '0;
        i_wvalid    = 1'b0;
        i_wdata     = '0;
        i_wstrb     = '0;
        i_bready    = 1'b0;
        i_arvalid   = 1'b0;
        i_araddr    = '0;
        i_rready    = 1'b0;
        i_vec       = '0;
        i_vec_valid = 1'b0;
        repeat (5) @(posedge i_clk);
        #1;
        i_sync_rst = 1'b0;

        // Idle outputs and cleared registers after reset.
        check_value("o_awready", 64'd0, 64'(o_awready));
        check_value("o_wready", 64'd0, 64'(o_wready));
        check_value("o_bvalid", 64'd0, 64'(o_bvalid));
        check_value("o_bresp", 64'd0, 64'(o_bresp));
        check_value("o_arready", 64'd0, 64'(o_arready));
        check_value("o_rvalid", 64'd0, 64'(o_rvalid));
        check_value("o_rdata", 64'd0, 64'(o_rdata));
        check_value("o_rresp", 64'd0, 64'(o_rresp));
        check_value("o_in_prod_valid", 64'd0, 64'(o_in_prod_valid));
        check_value("o_in_prod", 64'd0, 64'(o_in_prod));
        for (int i = 0; i < NREG; i++) bus_read(good_addr(2'(i)));

        // Full-word writes with read-back.
        for (int n = 0; n < N_FULL; n++) begin
            rnd  = next_rand();
            addr = good_addr(rnd[1:0]);
            bus_write(addr, next_rand(), 4'hf);
            bus_read(addr);
        end

        // Partial writes, only strobed bytes change.
        for (int n = 0; n < N_STRB; n++) begin
            rnd  = next_rand();
            addr = good_addr(rnd[1:0]);
            bus_write(addr, next_rand(), rnd[7:4]);
            bus_read(addr);
        end

        // Out-of-window accesses are rejected.
        for (int n = 0; n < N_BAD; n++) begin
            addr = next_rand();
            if (addr[ADDR_W-1:WIN_TOP] == '0) addr[WIN_TOP] = 1'b1;
            bus_write(addr, next_rand(), 4'hf);
            bus_read(addr);
        end
        for (int i = 0; i < NREG; i++) bus_read(good_addr(2'(i)));

        // Dot product bursts between coefficient updates.
        for (int r = 0; r < N_DOT_ROUNDS; r++) begin
            rnd = next_rand();
            bus_write(good_addr(rnd[1:0]), next_rand(), rnd[7:4]);
            for (int c = 0; c < DOT_BURST; c++) begin
                rnd  = next_rand();
                send = rnd[0] | rnd[1];
                i_vec_valid = send;
                for (int i = 0; i < NREG; i++) i_vec[i*DATA_W +: DATA_W] = next_rand();
                exp_prod = dot_model(i_vec);
                @(posedge i_clk);
                #1;
                check_value("o_in_prod_valid", 64'(send), 64'(o_in_prod_valid));
                if (send) check_value("o_in_prod", 64'(exp_prod), 64'(o_in_prod));
            end
            i_vec_valid = 1'b0;
            // No result follows the end of a burst.
            @(posedge i_clk);
            #1;
            check_value("o_in_prod_valid", 64'd0, 64'(o_in_prod_valid));
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* project.f */
lite_regs_pkg.sv
coef_reg_file.sv
inner_product_unit.sv
axil_write_channel.sv
axil_read_channel.sv
axil_coef_dot_top.sv
tb_axil_coef_dot.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_axil_coef_dot
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

# Build, run, and decide pass or fail from the log.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
